/* common/lcd_pkg.sv */
package lcd_pkg;

	// ------------------------------------------------------------------------
	// sequencer states
	// ------------------------------------------------------------------------
	typedef enum logic [2:0] {
		reset_hold,
		reset_wait,
		init_cmd,
		row_addr,
		row_char,
		busy_start,
		busy_read,
		idle
	} lcd_state_t;

	// start bytes of the 3-wire display bus
	typedef enum logic [7:0] {
		start_cmd_write  = 8'h1f,
		start_data_write = 8'h5f,
		start_busy_read  = 8'h3f
	} lcd_start_t;

	// ------------------------------------------------------------------------
	// bus and display geometry
	// ------------------------------------------------------------------------
	localparam int BUS_BITS = 8;

	localparam int LCD_ROWS = 4;
	localparam int LCD_COLS = 20;
	localparam int LCD_SIZE = LCD_ROWS * LCD_COLS;

	// ddram distance between rows
	localparam int ROW_STRIDE = 'h20;
	localparam logic [7:0] CMD_SET_ADDR = 8'h80;

	// busy flag position in the status byte
	localparam int BUSY_BIT = 7;

	// display reset pulse and settle time, in clocks
	localparam int RESET_CYCLES = 16;

	// init commands, extended set first, then clear and display on
	localparam int INIT_LEN = 12;
	localparam logic [7:0] lcd_init_seq [INIT_LEN] = '{
		8'h3a, 8'h09, 8'h06, 8'h1e,
		8'h39, 8'h1b, 8'h6e, 8'h57,
		8'h72, 8'h38, 8'h01, 8'h0c
	};

endpackage

/* common/serial_if.sv */
`timescale 1ns/1ps

interface serial_if
	import lcd_pkg::*;
();

	// transfer request, held high for as many words as wanted
	logic enable;

	// word to send, low bit first
	logic [BUS_BITS-1:0] tx_data;

	// word received during the last eight bits
	logic [BUS_BITS-1:0] rx_data;

	// one-cycle pulse per finished word
	logic next;

	// master idle and able to start
	logic ready;

	modport master (
		input  enable,
		input  tx_data,
		output rx_data,
		output next,
		output ready
	);

	modport ctrl (
		output enable,
		output tx_data,
		input  rx_data,
		input  next,
		input  ready
	);

endinterface

/* serial/serial_master.sv */
`timescale 1ns/1ps

module serial_master
	import lcd_pkg::*;
#(
	parameter int MAIN_CLK_HZ   = 50_000_000,
	parameter int SERIAL_CLK_HZ = 1_000_000
) (
	input  logic     clk50,
	input  logic     rst_n,
	serial_if.master bus,
	output logic     scl,
	output logic     sda_o,
	input  logic     sda_i
);

	// clocks per bit and per half bit
	localparam int BIT_CLKS  = MAIN_CLK_HZ / SERIAL_CLK_HZ;
	localparam int HALF_CLKS = (BIT_CLKS >= 2) ? BIT_CLKS / 2 : 1;
	localparam int CNT_W     = $clog2(BIT_CLKS + 1);
	localparam int BIT_W     = $clog2(BUS_BITS);

	typedef enum logic [1:0] {
		ser_idle,
		ser_shift,
		ser_stop
	} ser_state_t;

	ser_state_t          ser_state;
	logic [CNT_W-1:0]    clk_cnt;
	logic [BIT_W-1:0]    bit_cnt;
	logic [BUS_BITS-1:0] tx_shift;
	logic [BUS_BITS-1:0] rx_shift;
	logic [BUS_BITS-1:0] rx_word;
	logic                scl_r;
	logic                sda_r;
	logic                next_r;
	logic                ready_r;

	// ------------------------------------------------------------------------
	// bit timing and shifting
	// ------------------------------------------------------------------------
	always_ff @(posedge clk50) begin
		if (!rst_n) begin
			ser_state <= ser_idle;
			clk_cnt   <= '0;
			bit_cnt   <= '0;
			scl_r     <= 1'b1;
			sda_r     <= 1'b1;
			next_r    <= 1'b0;
			ready_r   <= 1'b1;
		end else begin
			next_r <= 1'b0;
			case (ser_state)
			ser_idle: begin
				// first falling edge puts out bit 0
				if (bus.enable) begin
					tx_shift  <= bus.tx_data >> 1;
					sda_r     <= bus.tx_data[0];
					scl_r     <= 1'b0;
					clk_cnt   <= '0;
					bit_cnt   <= '0;
					ready_r   <= 1'b0;
					ser_state <= ser_shift;
				end
			end
			ser_shift: begin
				if (clk_cnt == CNT_W'(HALF_CLKS - 1)) begin
					clk_cnt <= '0;
					if (!scl_r) begin
						// rising edge, sample input
						scl_r    <= 1'b1;
						rx_shift <= {sda_i, rx_shift[BUS_BITS-1:1]};
						if (bit_cnt == BIT_W'(BUS_BITS - 1)) begin
							next_r  <= 1'b1;
							rx_word <= {sda_i, rx_shift[BUS_BITS-1:1]};
						end
					end else if (bit_cnt != BIT_W'(BUS_BITS - 1)) begin
						// falling edge inside a word
						scl_r    <= 1'b0;
						sda_r    <= tx_shift[0];
						tx_shift <= tx_shift >> 1;
						bit_cnt  <= bit_cnt + 1'b1;
					end else if (bus.enable) begin
						// word boundary, continue with the next word
						scl_r    <= 1'b0;
						sda_r    <= bus.tx_data[0];
						tx_shift <= bus.tx_data >> 1;
						bit_cnt  <= '0;
					end else begin
						// enable gone, bus back to idle levels
						sda_r     <= 1'b1;
						ser_state <= ser_stop;
					end
				end else begin
					clk_cnt <= clk_cnt + 1'b1;
				end
			end
			default: begin
				// one bit time of idle before ready
				if (clk_cnt == CNT_W'(BIT_CLKS - 1)) begin
					clk_cnt   <= '0;
					ready_r   <= 1'b1;
					ser_state <= ser_idle;
				end else begin
					clk_cnt <= clk_cnt + 1'b1;
				end
			end
			endcase
		end
	end

	assign scl         = scl_r;
	assign sda_o       = sda_r;
	assign bus.next    = next_r;
	assign bus.ready   = ready_r;
	assign bus.rx_data = rx_word;

	// new transfers only start from an idle master
	a_enable_rise: assert property (@(posedge clk50) disable iff (!rst_n)
		$rose(bus.enable) |-> ready_r);

	a_next_pulse: assert property (@(posedge clk50) disable iff (!rst_n)
		next_r |=> !next_r);

endmodule

/* lcd/lcd_3wire.sv */
`timescale 1ns/1ps

module lcd_3wire
	import lcd_pkg::*;
(
	input  logic       clk50,
	input  logic       rst_n,
	input  logic       update,
	serial_if.ctrl     bus,
	output logic [6:0] char_addr,
	input  logic [7:0] char_data,
	output logic [7:0] busy_flag,
	output logic       lcd_rst
);

	localparam int RST_W = $clog2(RESET_CYCLES + 1);
	localparam int IDX_W = $clog2(INIT_LEN);
	localparam int ROW_W = $clog2(LCD_ROWS);
	localparam int COL_W = $clog2(LCD_COLS);

	lcd_state_t       state;
	lcd_state_t       after_busy;
	lcd_start_t       start_kind;
	logic [RST_W-1:0] rst_cnt;
	logic [IDX_W-1:0] init_idx;
	logic [ROW_W-1:0] row;
	logic [COL_W-1:0] col;
	logic [1:0]       word_cnt;
	logic [7:0]       frame_byte;
	logic [7:0]       payload;
	logic [7:0]       tx_word;
	logic             enable;
	logic             lcd_rst_r;
	logic             init_done;
	logic             upd_pending;
	logic             sending;
	logic             frame_go;
	logic             word_end;
	logic             frame_done;

	// ------------------------------------------------------------------------
	// frame contents
	// ------------------------------------------------------------------------
	assign char_addr = 7'(row * LCD_COLS + col);

	always_comb begin
		case (state)
		init_cmd: payload = lcd_init_seq[init_idx];
		row_addr: payload = 8'(CMD_SET_ADDR + row * ROW_STRIDE);
		row_char: payload = char_data;
		default:  payload = 8'h00;
		endcase
	end

	// start byte, then low nibble, then high nibble
	always_comb begin
		start_kind = (state == row_char) ? start_data_write : start_cmd_write;
		case (state)
		busy_start: tx_word = start_busy_read;
		busy_read:  tx_word = 8'h00;
		default: begin
			case (word_cnt)
			2'd0:    tx_word = start_kind;
			2'd1:    tx_word = {4'h0, frame_byte[3:0]};
			default: tx_word = {4'h0, frame_byte[7:4]};
			endcase
		end
		endcase
	end

	assign sending    = state inside {init_cmd, row_addr, row_char, busy_start};
	assign frame_go   = sending && !enable && bus.ready;
	assign word_end   = enable && bus.next;
	assign frame_done = word_end && (word_cnt == 2'd2);

	// ------------------------------------------------------------------------
	// sequencer
	// ------------------------------------------------------------------------
	always_ff @(posedge clk50) begin
		if (!rst_n) begin
			state       <= reset_hold;
			after_busy  <= idle;
			rst_cnt     <= '0;
			init_idx    <= '0;
			row         <= '0;
			col         <= '0;
			word_cnt    <= '0;
			enable      <= 1'b0;
			busy_flag   <= '0;
			lcd_rst_r   <= 1'b0;
			init_done   <= 1'b0;
			upd_pending <= 1'b0;
		end else begin
			// early update, served once init is through
			if (update && !init_done)
				upd_pending <= 1'b1;

			// common frame start and word stepping
			if (frame_go) begin
				enable     <= 1'b1;
				word_cnt   <= '0;
				frame_byte <= payload;
			end else if (word_end) begin
				word_cnt <= word_cnt + 1'b1;
			end

			case (state)
			reset_hold: begin
				rst_cnt <= rst_cnt + 1'b1;
				if (rst_cnt == RST_W'(RESET_CYCLES - 1)) begin
					rst_cnt   <= '0;
					lcd_rst_r <= 1'b1;
					state     <= reset_wait;
				end
			end
			reset_wait: begin
				rst_cnt <= rst_cnt + 1'b1;
				if (rst_cnt == RST_W'(RESET_CYCLES - 1)) begin
					rst_cnt  <= '0;
					init_idx <= '0;
					state    <= init_cmd;
				end
			end
			init_cmd: begin
				if (frame_done) begin
					enable <= 1'b0;
					state  <= busy_start;
					if (init_idx == IDX_W'(INIT_LEN - 1)) begin
						after_busy <= idle;
					end else begin
						after_busy <= init_cmd;
						init_idx   <= init_idx + 1'b1;
					end
				end
			end
			row_addr: begin
				if (frame_done) begin
					enable     <= 1'b0;
					col        <= '0;
					after_busy <= row_char;
					state      <= busy_start;
				end
			end
			row_char: begin
				// data writes go out back to back
				if (frame_done) begin
					enable <= 1'b0;
					if (col == COL_W'(LCD_COLS - 1)) begin
						col <= '0;
						if (row == ROW_W'(LCD_ROWS - 1)) begin
							row   <= '0;
							state <= idle;
						end else begin
							row   <= row + 1'b1;
							state <= row_addr;
						end
					end else begin
						col <= col + 1'b1;
					end
				end
			end
			busy_start: begin
				if (word_end)
					state <= busy_read;
			end
			busy_read: begin
				if (word_end) begin
					enable    <= 1'b0;
					busy_flag <= bus.rx_data;
					if (bus.rx_data[BUSY_BIT]) begin
						state <= busy_start;
					end else begin
						state <= after_busy;
						if (after_busy == idle)
							init_done <= 1'b1;
					end
				end
			end
			default: begin
				// idle, wait for an update
				if (update || upd_pending) begin
					upd_pending <= 1'b0;
					row         <= '0;
					col         <= '0;
					state       <= row_addr;
				end
			end
			endcase
		end
	end

	assign bus.enable  = enable;
	assign bus.tx_data = tx_word;
	assign lcd_rst     = lcd_rst_r;

	a_addr_range: assert property (@(posedge clk50) disable iff (!rst_n)
		char_addr < 7'(LCD_SIZE));

	// display reset only while holding
	a_rst_hold: assert property (@(posedge clk50) disable iff (!rst_n)
		!lcd_rst |-> state == reset_hold);

endmodule

/* source/text_buffer.sv */
`timescale 1ns/1ps

module text_buffer
	import lcd_pkg::*;
(
	input  logic       clk50,
	input  logic       rst_n,
	input  logic       wr_en,
	input  logic [6:0] wr_addr,
	input  logic [7:0] wr_char,
	input  logic [6:0] rd_addr,
	output logic [7:0] rd_char
);

	logic [7:0] mem [LCD_SIZE];

	// ------------------------------------------------------------------------
	// character store
	// ------------------------------------------------------------------------
	always_ff @(posedge clk50) begin
		if (!rst_n) begin
			// repeating alphabet from 'A'
			for (int i = 0; i < LCD_SIZE; i++)
				mem[i] <= 8'(8'h41 + i % 26);
		end else if (wr_en && (wr_addr < 7'(LCD_SIZE))) begin
			mem[wr_addr] <= wr_char;
		end
	end

	// combinational read, blank outside the display
	assign rd_char = (rd_addr < 7'(LCD_SIZE)) ? mem[rd_addr] : 8'h20;

	// preload and writes never overlap
	a_no_write_in_reset: assert property (@(posedge clk50)
		!rst_n |-> !wr_en);

endmodule

/* source/sevenseg_mux.sv */
`timescale 1ns/1ps

module sevenseg_mux #(
	parameter int MAIN_CLK_HZ = 50_000_000,
	parameter int SEVENSEG_HZ = 100
) (
	input  logic       clk50,
	input  logic       rst_n,
	input  logic [7:0] value,
	output logic [6:0] seg,
	output logic       seg_sel
);

	localparam int TICK_CLKS = (MAIN_CLK_HZ / SEVENSEG_HZ > 0) ? MAIN_CLK_HZ / SEVENSEG_HZ : 1;
	localparam int TICK_W    = $clog2(TICK_CLKS + 1);

	logic [TICK_W-1:0] tick_cnt;
	logic [3:0]        nibble;
	logic [6:0]        font;

	// refresh tick, one digit change per tick
	always_ff @(posedge clk50) begin
		if (!rst_n) begin
			tick_cnt <= '0;
			seg_sel  <= 1'b0;
		end else if (tick_cnt == TICK_W'(TICK_CLKS - 1)) begin
			tick_cnt <= '0;
			seg_sel  <= ~seg_sel;
		end else begin
			tick_cnt <= tick_cnt + 1'b1;
		end
	end

	assign nibble = seg_sel ? value[7:4] : value[3:0];

	// hex font, segment a in bit 0
	always_comb begin
		case (nibble)
		4'h0: font = 7'h3f;
		4'h1: font = 7'h06;
		4'h2: font = 7'h5b;
		4'h3: font = 7'h4f;
		4'h4: font = 7'h66;
		4'h5: font = 7'h6d;
		4'h6: font = 7'h7d;
		4'h7: font = 7'h07;
		4'h8: font = 7'h7f;
		4'h9: font = 7'h6f;
		4'ha: font = 7'h77;
		4'hb: font = 7'h7c;
		4'hc: font = 7'h39;
		4'hd: font = 7'h5e;
		4'he: font = 7'h79;
		default: font = 7'h71;
		endcase
	end

	// segments light on a low level
	assign seg = ~font;

endmodule

/* source/lcd_text_top.sv */
`timescale 1ns/1ps

module lcd_text_top
	import lcd_pkg::*;
#(
	parameter int MAIN_CLK_HZ   = 50_000_000,
	parameter int SERIAL_CLK_HZ = 1_000_000,
	parameter int SEVENSEG_HZ   = 100
) (
	input  logic                clk50,
	input  logic                rst_n,
	input  logic                update,
	input  logic                wr_en,
	input  logic [6:0]          wr_addr,
	input  logic [BUS_BITS-1:0] wr_char,
	output logic                lcd_scl,
	output logic                lcd_sda_o,
	input  logic                lcd_sda_i,
	output logic                lcd_rst,
	output logic [6:0]          seg,
	output logic                seg_sel
);

	// sequencer to serial master
	serial_if sbus ();

	logic [6:0] char_addr;
	logic [7:0] char_data;
	logic [7:0] busy_flag;

	// ------------------------------------------------------------------------
	// display bus
	// ------------------------------------------------------------------------
	serial_master #(
		.MAIN_CLK_HZ(MAIN_CLK_HZ),
		.SERIAL_CLK_HZ(SERIAL_CLK_HZ)
	) u_serial (
		.clk50(clk50), .rst_n(rst_n), .bus(sbus.master),
		.scl(lcd_scl), .sda_o(lcd_sda_o), .sda_i(lcd_sda_i)
	);

	lcd_3wire u_lcd (
		.clk50(clk50), .rst_n(rst_n), .update(update), .bus(sbus.ctrl),
		.char_addr(char_addr), .char_data(char_data),
		.busy_flag(busy_flag), .lcd_rst(lcd_rst)
	);

	// ------------------------------------------------------------------------
	// text and status display
	// ------------------------------------------------------------------------
	text_buffer u_buf (
		.clk50(clk50), .rst_n(rst_n), .wr_en(wr_en), .wr_addr(wr_addr),
		.wr_char(wr_char), .rd_addr(char_addr), .rd_char(char_data)
	);

	// last busy byte as two hex digits
	sevenseg_mux #(
		.MAIN_CLK_HZ(MAIN_CLK_HZ),
		.SEVENSEG_HZ(SEVENSEG_HZ)
	) u_seg (
		.clk50(clk50), .rst_n(rst_n), .value(busy_flag),
		.seg(seg), .seg_sel(seg_sel)
	);

endmodule

/* verif/lcd_bus_model.sv */
`timescale 1ns/1ps

module lcd_bus_model
	import lcd_pkg::*;
(
	input  logic       clk50,
	input  logic       lcd_rst,
	input  logic       scl,
	input  logic       sda,
	output logic       sda_i,
	output logic       frame_valid,
	output logic [1:0] frame_kind,
	output logic [7:0] frame_byte
);

	logic       scl_q;
	logic [2:0] bit_cnt;
	logic [1:0] byte_cnt;
	logic [7:0] shift;
	logic [7:0] word;
	logic [7:0] start;
	logic [7:0] low_byte;
	logic [7:0] value;
	logic [6:0] addr;
	logic [1:0] busy_left;
	logic [7:0] reply;

	initial begin
		sda_i       = 1'b1;
		frame_valid = 1'b0;
		scl_q       = 1'b1;
	end

	// bit 0 comes first on the wire
	assign word  = {sda, shift[7:1]};
	assign value = {word[3:0], low_byte[3:0]};
	// flag stays set while polls are still owed
	assign reply = {busy_left != 2'd0, addr};

	// ------------------------------------------------------------------------
	// bus decode, one step per detected scl edge
	// ------------------------------------------------------------------------
	always @(posedge clk50) begin
		frame_valid <= 1'b0;
		scl_q       <= scl;
		if (lcd_rst !== 1'b1) begin
			bit_cnt   <= '0;
			byte_cnt  <= '0;
			addr      <= '0;
			busy_left <= '0;
			sda_i     <= 1'b1;
		end else if (scl && !scl_q) begin
			shift   <= word;
			bit_cnt <= bit_cnt + 3'd1;
			if (bit_cnt == 3'd7) begin
				case (byte_cnt)
				2'd0: begin
					start    <= word;
					byte_cnt <= 2'd1;
				end
				2'd1: begin
					if (start == start_busy_read) begin
						frame_valid <= 1'b1;
						frame_kind  <= 2'd2;
						frame_byte  <= reply;
						byte_cnt    <= 2'd0;
						if (busy_left != 2'd0)
							busy_left <= busy_left - 2'd1;
					end else begin
						low_byte <= word;
						byte_cnt <= 2'd2;
					end
				end
				default: begin
					frame_valid <= 1'b1;
					frame_byte  <= value;
					byte_cnt    <= 2'd0;
					// kind 3 marks a broken frame
					if ({low_byte[7:4], word[7:4]} != 8'h00) begin
						frame_kind <= 2'd3;
					end else if (start == start_cmd_write) begin
						frame_kind <= 2'd0;
						if (value == 8'h01) begin
							addr      <= '0;
							busy_left <= 2'd3;
						end else if (value[7]) begin
							addr <= value[6:0];
						end
					end else if (start == start_data_write) begin
						frame_kind <= 2'd1;
						addr       <= addr + 7'd1;
					end else begin
						frame_kind <= 2'd3;
					end
				end
				endcase
			end
		end else if (!scl && scl_q) begin
			// reply bit ready before the next rising edge
			if (byte_cnt == 2'd1 && start == start_busy_read)
				sda_i <= reply[bit_cnt];
			else
				sda_i <= 1'b1;
		end
	end

endmodule

/* verif/tb_lcd_text.sv */
`timescale 1ns/1ps

module tb_lcd_text
	import lcd_pkg::*;
();

	localparam int MAIN_HZ     = 8;
	localparam int SERIAL_HZ   = 2;
	localparam int SEG_HZ      = 1;
	localparam int MAX_CYCLES  = 60000;
	localparam int RAND_WRITES = 24;
	localparam int SETTLE_CLKS = 4 * (MAIN_HZ / SERIAL_HZ);
	localparam int QUIET_CLKS  = 500;
	// lit segments per hex digit with a in bit 0
	localparam logic [6:0] LIT [16] = '{7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d,
		7'h7d, 7'h07, 7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71};

	logic       clk50 = 1'b0;
	logic       rst_n;
	logic       update;
	logic       wr_en;
	logic [6:0] wr_addr;
	logic [7:0] wr_char;
	logic       lcd_scl;
	logic       lcd_sda_o;
	logic       lcd_sda_i;
	logic       lcd_rst;
	logic [6:0] seg;
	logic       seg_sel;
	logic       frame_valid;
	logic [1:0] frame_kind;
	logic [7:0] frame_byte;

	// expected entries as {kind, byte}
	logic [9:0] exp_q [$];
	logic [9:0] exp_entry;
	logic [7:0] buf_copy [LCD_SIZE];
	logic [6:0] ref_addr;
	logic [7:0] last_busy;
	logic [6:0] rand_addr;
	logic [7:0] rand_char;
	int         ref_busy_left;
	int         frames_checked = 0;
	int         cycles = 0;
	int         low_cycles;
	int         mark;
	int         seed;

	always #4 clk50 = ~clk50;

	lcd_text_top #(
		.MAIN_CLK_HZ(MAIN_HZ),
		.SERIAL_CLK_HZ(SERIAL_HZ),
		.SEVENSEG_HZ(SEG_HZ)
	) uut (
		.clk50(clk50), .rst_n(rst_n), .update(update), .wr_en(wr_en),
		.wr_addr(wr_addr), .wr_char(wr_char), .lcd_scl(lcd_scl),
		.lcd_sda_o(lcd_sda_o), .lcd_sda_i(lcd_sda_i), .lcd_rst(lcd_rst),
		.seg(seg), .seg_sel(seg_sel)
	);

	lcd_bus_model model (
		.clk50(clk50), .lcd_rst(lcd_rst), .scl(lcd_scl), .sda(lcd_sda_o),
		.sda_i(lcd_sda_i), .frame_valid(frame_valid), .frame_kind(frame_kind),
		.frame_byte(frame_byte)
	);

	task automatic flag_mismatch(input string name, input int got_val, input int exp_val);
		$display("[ERROR] %0t ns %s got %0h expected %0h", $time, name, got_val, exp_val);
		$display("TB FAILED");
		$fatal(1, "value check failed");
	endtask

	task automatic abort_run(input string what);
		$display("%0t ns %s", $time, what);
		$display("TB FAILED");
		$fatal(1, "run aborted");
	endtask

	// ------------------------------------------------------------------------
	// reference model of the frame stream
	// ------------------------------------------------------------------------
	function automatic void push_entry(input logic [1:0] kind, input logic [7:0] val);
		exp_q.push_back({kind, val});
	endfunction

	// command followed by the busy polls it causes
	function automatic void expect_command(input logic [7:0] cmd);
		push_entry(2'd0, cmd);
		if (cmd == 8'h01) begin
			ref_addr      = '0;
			ref_busy_left = 3;
		end else if (cmd[7]) begin
			ref_addr = cmd[6:0];
		end
		for (; ref_busy_left > 0; ref_busy_left--)
			push_entry(2'd2, {1'b1, ref_addr});
		push_entry(2'd2, {1'b0, ref_addr});
		last_busy = {1'b0, ref_addr};
	endfunction

	function automatic void build_expected(input bit with_init);
		if (with_init) begin
			ref_addr      = '0;
			ref_busy_left = 0;
			for (int i = 0; i < INIT_LEN; i++)
				expect_command(lcd_init_seq[i]);
		end else begin
			for (int r = 0; r < LCD_ROWS; r++) begin
				expect_command(8'(int'(CMD_SET_ADDR) + r * ROW_STRIDE));
				// data frames carry no busy poll
				for (int c = 0; c < LCD_COLS; c++) begin
					push_entry(2'd1, buf_copy[r * LCD_COLS + c]);
					ref_addr = ref_addr + 7'd1;
				end
			end
		end
	endfunction

	// ------------------------------------------------------------------------
	// compare and watchdog
	// ------------------------------------------------------------------------
	always @(posedge clk50) begin
		if (frame_valid) begin
			assert (exp_q.size() > 0) else abort_run("display frame arrived with none expected");
			exp_entry = exp_q.pop_front();
			assert (frame_kind == exp_entry[9:8])
				else flag_mismatch("frame_kind", int'(frame_kind), int'(exp_entry[9:8]));
			assert (frame_byte == exp_entry[7:0])
				else flag_mismatch("frame_byte", int'(frame_byte), int'(exp_entry[7:0]));
			frames_checked++;
		end
	end

	always @(posedge clk50) begin
		cycles++;
		assert (cycles < MAX_CYCLES) else abort_run("timeout, display frames did not finish");
	end

	task automatic pulse_update();
		@(posedge clk50);
		#1;
		update = 1'b1;
		@(posedge clk50);
		#1;
		update = 1'b0;
	endtask

	task automatic write_char(input logic [6:0] addr, input logic [7:0] ch);
		@(posedge clk50);
		#1;
		wr_en   = 1'b1;
		wr_addr = addr;
		wr_char = ch;
		@(posedge clk50);
		#1;
		wr_en = 1'b0;
		if (addr < 7'(LCD_SIZE))
			buf_copy[addr] = ch;
	endtask

	// all expected frames seen and sequencer back in idle
	task automatic wait_drained();
		while (exp_q.size() != 0) begin
			@(posedge clk50);
			#1;
		end
		repeat (SETTLE_CLKS) @(posedge clk50);
		#1;
	endtask

	task automatic check_digits();
		logic [6:0] exp_seg;
		bit         seen_lo;
		bit         seen_hi;
		seen_lo = 1'b0;
		seen_hi = 1'b0;
		repeat (5 * MAIN_HZ / SEG_HZ) begin
			@(posedge clk50);
			#1;
			exp_seg = ~LIT[seg_sel ? last_busy[7:4] : last_busy[3:0]];
			assert (seg == exp_seg) else flag_mismatch("seg", int'(seg), int'(exp_seg));
			if (seg_sel)
				seen_hi = 1'b1;
			else
				seen_lo = 1'b1;
		end
		assert (seen_lo && seen_hi) else abort_run("seg_sel did not alternate between digits");
	endtask

	// ------------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------------
	initial begin
		seed    = 32'h82a9;
		rst_n   = 1'b0;
		update  = 1'b0;
		wr_en   = 1'b0;
		wr_addr = '0;
		wr_char = '0;
		for (int i = 0; i < LCD_SIZE; i++)
			buf_copy[i] = 8'(8'h41 + i % 26);
		build_expected(1'b1);
		repeat (4) @(posedge clk50);
		#1;
		rst_n = 1'b1;

		// display reset pulse length
		low_cycles = 0;
		while (lcd_rst == 1'b0 && low_cycles <= RESET_CYCLES + 4) begin
			low_cycles++;
			@(posedge clk50);
			#1;
		end
		assert (low_cycles == RESET_CYCLES)
			else flag_mismatch("lcd_rst low cycles", low_cycles, RESET_CYCLES);
		wait_drained();

		// preloaded alphabet
		build_expected(1'b0);
		pulse_update();
		wait_drained();

		// random text with some addresses past the end
		for (int k = 0; k < RAND_WRITES; k++) begin
			rand_addr = 7'($unsigned($random(seed)) % 96);
			rand_char = 8'($random(seed));
			write_char(rand_addr, rand_char);
		end
		write_char(7'h5a, 8'h7e);
		build_expected(1'b0);
		pulse_update();
		wait_drained();
		check_digits();

		// second pulse lands in the middle of row data
		build_expected(1'b0);
		mark = frames_checked + 30;
		pulse_update();
		while (frames_checked < mark) begin
			@(posedge clk50);
			#1;
		end
		pulse_update();
		wait_drained();
		repeat (QUIET_CLKS) @(posedge clk50);
		#1;

		// bus back at idle levels after the last frame
		if (lcd_scl === 1'b1 && lcd_sda_o === 1'b1) begin
			$display("TB PASSED");
			$finish;
		end else begin
			$display("%0t ns display bus not idle after the last frame", $time);
			$display("TB FAILED");
			$fatal(1, "bus not idle");
		end
	end

endmodule

/* files.f */
common/lcd_pkg.sv
common/serial_if.sv
serial/serial_master.sv
lcd/lcd_3wire.sv
source/text_buffer.sv
source/sevenseg_mux.sv
source/lcd_text_top.sv
verif/lcd_bus_model.sv
verif/tb_lcd_text.sv

/* Makefile */
# Verilator build of the display text testbench

VERILATOR ?= verilator
TOP       ?= tb_lcd_text
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulation is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
